/* hdl/fb_dsp_pkg.sv */
`default_nettype none

// datapath widths and number formats for the bunch-by-bunch feedback
package fb_dsp_pkg;

	// ##################################################################
	// widths

	// pickup sum and difference, const code and dac code
	localparam int sample_w = 13;
	// gain table word, 4096 * gain / sigma
	localparam int gain_w = 21;
	// table address comes straight from sigma
	localparam int lut_addr_w = sample_w;
	// accumulator, matches a dsp48 p output
	localparam int acc_w = 48;
	// table words carry a x4096 factor, removed before the dac
	localparam int scale_shift = 12;

	// ##################################################################
	// types

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic signed [gain_w-1:0] gain_t;
	typedef logic signed [acc_w-1:0] acc_t;

	// full-scale dac codes, two's complement
	localparam sample_t dac_max = sample_t'(4095);
	localparam sample_t dac_min = sample_t'(-4096);

endpackage

`default_nettype wire

/* hdl/fb_timing_pkg.sv */
`default_nettype none

// strobe chain layout and output source selection
package fb_timing_pkg;

	// stages a..h
	localparam int chain_len = 8;

	// stage e, products are valid here so stores load on it
	localparam int capture_stage = 4;

	// stages f and g give the two-cycle dac enable
	localparam int dac_first_stage = 5;
	localparam int dac_last_stage = 6;

	// what the amplifier drive register loads
	typedef enum logic [1:0] {
		src_zero,
		src_const,
		src_loop
	} drive_src_e;

endpackage

`default_nettype wire

/* hdl/strobe_if.sv */
`timescale 1ns/1ns
`default_nettype none

// strobe chain taps handed to the datapath blocks
interface strobe_if;

	// one cycle at store falling edge, clears the loop
	logic zero_strb;
	// stage e of each chain, gated with store
	logic p2_capture;
	logic p3_capture;
	// raw p3 stage e, zero strobe pulse included
	logic p3_stage_e;
	// stage f or g
	logic dac_en_next;

	modport source (
		output zero_strb,
		output p2_capture,
		output p3_capture,
		output p3_stage_e,
		output dac_en_next
	);

	// loop registers
	modport acc (
		input zero_strb,
		input p2_capture,
		input p3_capture
	);

	// dac register and enable
	modport out (
		input p3_stage_e,
		input dac_en_next
	);

endinterface

`default_nettype wire

/* hdl/strobe_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module strobe_timing import fb_timing_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic store_strb,
	input  logic p2_bunch_strb,
	input  logic p3_bunch_strb,
	strobe_if.source strb
);

	// ##################################################################
	// store edge detect

	logic store_a;
	logic store_b;
	logic zero_strb;

	// two flops, store comes from the ring timing system
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			store_a <= 1'b0;
			store_b <= 1'b0;
		end else begin
			store_a <= store_strb;
			store_b <= store_a;
		end
	end

	// high for one cycle once store has gone low
	assign zero_strb = store_b & ~store_a;

	// ##################################################################
	// bunch strobe chains

	// bit 0 is stage a, bit capture_stage is stage e
	logic [chain_len-1:0] p2_chain;
	logic [chain_len-1:0] p3_chain;

	// zero strobe rides both chains so the dac gets a final zero kick
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p2_chain <= '0;
			p3_chain <= '0;
		end else begin
			p2_chain <= {p2_chain[chain_len-2:0], p2_bunch_strb | zero_strb};
			p3_chain <= {p3_chain[chain_len-2:0], p3_bunch_strb | zero_strb};
		end
	end

	// ##################################################################
	// taps

	assign strb.zero_strb = zero_strb;

	// stores only load during an active store period
	assign strb.p2_capture = p2_chain[capture_stage] & store_strb;
	assign strb.p3_capture = p3_chain[capture_stage] & store_strb;

	// dac register loads on every stage e pulse, zero strobe included
	assign strb.p3_stage_e = p3_chain[capture_stage];

	// registered once more in the output stage, two cycles wide
	assign strb.dac_en_next = p3_chain[dac_first_stage] | p3_chain[dac_last_stage];

endmodule

`default_nettype wire

/* hdl/pickup_scaler.sv */
`timescale 1ns/1ns
`default_nettype none

module pickup_scaler import fb_dsp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  sample_t               sigma,
	input  sample_t               delta,
	input  logic                  lut_we,
	input  logic [lut_addr_w-1:0] lut_addr,
	input  gain_t                 lut_data,
	output acc_t                  product
);

	// ##################################################################
	// gain table
	//
	// normalising load is 4096 * gain / sigma per address,
	// flat load of 4096 * gain turns normalisation off

	gain_t lut [0:(1 << lut_addr_w)-1];
	logic [lut_addr_w-1:0] rd_addr;
	gain_t lut_rd;
	gain_t lut_reg;

	// sigma bits index the table directly
	assign rd_addr = unsigned'(sigma);

	always_ff @(posedge clk) begin
		if (lut_we) begin
			lut[lut_addr] <= lut_data;
		end
	end

	// block ram read port, then one register for timing
	always_ff @(posedge clk) begin
		lut_rd <= lut[rd_addr];
		lut_reg <= lut_rd;
	end

	// ##################################################################
	// delta alignment

	// two stages, matching read plus output register
	sample_t delta_a;
	sample_t delta_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			delta_a <= '0;
			delta_b <= '0;
		end else begin
			delta_a <= delta;
			delta_b <= delta_a;
		end
	end

	// ##################################################################
	// multiply, three stages

	gain_t op_gain;
	sample_t op_delta;
	logic signed [gain_w+sample_w-1:0] prod;

	// operand regs, product reg, then widen to accumulator format
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_gain <= '0;
			op_delta <= '0;
			prod <= '0;
			product <= '0;
		end else begin
			op_gain <= lut_reg;
			op_delta <= delta_b;
			prod <= op_gain * op_delta;
			// sign extend
			product <= acc_t'(prod);
		end
	end

endmodule

`default_nettype wire

/* hdl/kick_accumulator.sv */
`timescale 1ns/1ns
`default_nettype none

module kick_accumulator import fb_dsp_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  acc_t p2_product,
	input  acc_t p3_product,
	input  logic delay_loop_en,
	strobe_if.acc strb,
	output acc_t loop_sum
);

	// ##################################################################
	// p2 store and delay loop
	//
	// p2 kick part is held until its p3 partner arrives,
	// p3 closes the loop through delay_loop

	acc_t p2_store;
	acc_t delay_loop;
	// delay loop plus p2 store, one register
	acc_t loop_in;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p2_store <= '0;
			delay_loop <= '0;
		end else if (strb.zero_strb) begin
			// end of store period, start the next one empty
			p2_store <= '0;
			delay_loop <= '0;
		end else begin
			if (strb.p2_capture) begin
				p2_store <= p2_product;
			end
			if (strb.p3_capture) begin
				// loop disabled means each kick stands alone
				delay_loop <= delay_loop_en ? loop_sum : '0;
			end
		end
	end

	// ready well before the next p3 product, spacing is 8 cycles min
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			loop_in <= '0;
		end else if (strb.zero_strb) begin
			loop_in <= '0;
		end else begin
			loop_in <= delay_loop + p2_store;
		end
	end

	// ##################################################################
	// loop sum

	// feeds both the delay loop and the dac stage
	assign loop_sum = p3_product + loop_in;

endmodule

`default_nettype wire

/* hdl/dac_output_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module dac_output_stage
	import fb_dsp_pkg::*;
	import fb_timing_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  acc_t    loop_sum,
	input  logic    store_strb,
	input  logic    feedbck_en,
	input  logic    const_dac_en,
	input  sample_t const_dac_code,
	strobe_if.out   strb,
	output sample_t amp_drive,
	output logic    dac_en
);

	// ##################################################################
	// scale and saturate

	acc_t scaled;
	sample_t sat_code;

	// remove the x4096 of the gain tables, truncates toward -inf
	assign scaled = loop_sum >>> scale_shift;

	// clamp to full-scale dac codes
	always_comb begin
		if (scaled > acc_t'(dac_max)) begin
			sat_code = dac_max;
		end else if (scaled < acc_t'(dac_min)) begin
			sat_code = dac_min;
		end else begin
			sat_code = sample_t'(scaled);
		end
	end

	// ##################################################################
	// output select

	drive_src_e drive_src;
	sample_t drive_code;

	// zero wins over constant, constant over loop
	always_comb begin
		if (!store_strb || !feedbck_en) begin
			drive_src = src_zero;
		end else if (const_dac_en) begin
			drive_src = src_const;
		end else begin
			drive_src = src_loop;
		end
	end

	always_comb begin
		case (drive_src)
			src_const: drive_code = const_dac_code;
			src_loop:  drive_code = sat_code;
			default:   drive_code = '0;
		endcase
	end

	// ##################################################################
	// dac registers

	// code settles one cycle before dac_en rises
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			amp_drive <= '0;
			dac_en <= 1'b0;
		end else begin
			if (strb.p3_stage_e) begin
				amp_drive <= drive_code;
			end
			dac_en <= strb.dac_en_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/fb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fb_top import fb_dsp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  store_strb,
	input  logic                  p2_bunch_strb,
	input  logic                  p3_bunch_strb,
	input  logic                  feedbck_en,
	input  logic                  delay_loop_en,
	input  logic                  const_dac_en,
	input  sample_t               p2_sigma,
	input  sample_t               p2_delta,
	input  sample_t               p3_sigma,
	input  sample_t               p3_delta,
	input  sample_t               const_dac_code,
	input  logic                  p2_lut_we,
	input  logic                  p3_lut_we,
	input  logic [lut_addr_w-1:0] p2_lut_addr,
	input  logic [lut_addr_w-1:0] p3_lut_addr,
	input  gain_t                 p2_lut_data,
	input  gain_t                 p3_lut_data,
	output sample_t               amp_drive,
	output logic                  dac_en
);

	// ##################################################################
	// strobe timing

	strobe_if strb ();

	strobe_timing strb_timing (
		.clk           (clk),
		.rst           (rst),
		.store_strb    (store_strb),
		.p2_bunch_strb (p2_bunch_strb),
		.p3_bunch_strb (p3_bunch_strb),
		.strb          (strb.source)
	);

	// ##################################################################
	// per-pickup gain x delta, 5 cycles each

	acc_t p2_product;
	acc_t p3_product;

	pickup_scaler p2_scaler (
		.clk      (clk),
		.rst      (rst),
		.sigma    (p2_sigma),
		.delta    (p2_delta),
		.lut_we   (p2_lut_we),
		.lut_addr (p2_lut_addr),
		.lut_data (p2_lut_data),
		.product  (p2_product)
	);

	pickup_scaler p3_scaler (
		.clk      (clk),
		.rst      (rst),
		.sigma    (p3_sigma),
		.delta    (p3_delta),
		.lut_we   (p3_lut_we),
		.lut_addr (p3_lut_addr),
		.lut_data (p3_lut_data),
		.product  (p3_product)
	);

	// ##################################################################
	// kick sum and dac

	acc_t loop_sum;

	kick_accumulator kick_acc (
		.clk           (clk),
		.rst           (rst),
		.p2_product    (p2_product),
		.p3_product    (p3_product),
		.delay_loop_en (delay_loop_en),
		.strb          (strb.acc),
		.loop_sum      (loop_sum)
	);

	dac_output_stage dac_out (
		.clk            (clk),
		.rst            (rst),
		.loop_sum       (loop_sum),
		.store_strb     (store_strb),
		.feedbck_en     (feedbck_en),
		.const_dac_en   (const_dac_en),
		.const_dac_code (const_dac_code),
		.strb           (strb.out),
		.amp_drive      (amp_drive),
		.dac_en         (dac_en)
	);

endmodule

`default_nettype wire

/* verification/fb_top_chk.sv */
`timescale 1ns/1ns
`default_nettype none

// strobe spacing and dac output timing, bound into fb_top
module fb_top_chk
	import fb_dsp_pkg::*;
(
	input wire logic    clk,
	input wire logic    rst,
	input wire logic    p2_bunch_strb,
	input wire logic    p3_bunch_strb,
	input wire sample_t amp_drive,
	input wire logic    dac_en
);

	// ##################################################################
	// cycles since the last bunch strobe, saturating

	logic [3:0] p2_gap;
	logic [3:0] p3_gap;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p2_gap <= '1;
			p3_gap <= '1;
		end else begin
			if (p2_bunch_strb) begin
				p2_gap <= '0;
			end else if (p2_gap != '1) begin
				p2_gap <= p2_gap + 4'd1;
			end
			if (p3_bunch_strb) begin
				p3_gap <= '0;
			end else if (p3_gap != '1) begin
				p3_gap <= p3_gap + 4'd1;
			end
		end
	end

	// ##################################################################
	// properties

	// p3 strobes 8 cycles apart or more
	a_p3_spacing: assert property (@(posedge clk) disable iff (rst)
		p3_bunch_strb |-> p3_gap >= 4'd7)
		else $error("p3 bunch strobes closer than 8 cycles");

	// p2 leads its p3 partner by 8 cycles or more
	a_p2_lead: assert property (@(posedge clk) disable iff (rst)
		p3_bunch_strb |-> p2_gap >= 4'd7)
		else $error("p2 bunch strobe less than 8 cycles before p3");

	// high on exactly two samples before falling
	a_dac_en_width: assert property (@(posedge clk) disable iff (rst)
		$fell(dac_en) |-> $past(dac_en, 2) && !$past(dac_en, 3))
		else $error("dac_en pulse is not two cycles long");

	// code is loaded a cycle ahead of the enable
	a_drive_stable: assert property (@(posedge clk) disable iff (rst)
		dac_en |-> $stable(amp_drive))
		else $error("amp_drive changed while dac_en was high");

	// outputs idle when reset lets go
	a_reset_idle: assert property (@(posedge clk)
		$fell(rst) |-> !dac_en && amp_drive == '0)
		else $error("dac outputs not idle after reset");

endmodule

bind fb_top fb_top_chk i_chk (
	.clk           (clk),
	.rst           (rst),
	.p2_bunch_strb (p2_bunch_strb),
	.p3_bunch_strb (p3_bunch_strb),
	.amp_drive     (amp_drive),
	.dac_en        (dac_en)
);

`default_nettype wire

/* verification/tb_fb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fb_top
	import fb_dsp_pkg::*;
();

	// ##################################################################
	// constants

	localparam logic [31:0] seed = 32'h04ff79b7;
	localparam int clk_period = 8;
	localparam int drive_dly = 1;
	// upper bound on bunches in the run
	localparam int n_bunches = 32;
	// p2 to p3 strobe distance
	localparam int strobe_gap = 8;
	// cycle budget per bunch
	localparam int bunch_cycles = 32;
	localparam int lut_depth = 1 << lut_addr_w;
	// strobe to dac_en is 7 cycles
	localparam int dac_wait = 16;
	localparam int timeout_ns = (lut_depth + n_bunches * bunch_cycles + 200) * clk_period;

	typedef logic [lut_addr_w-1:0] addr_t;

	// ##################################################################
	// dut

	logic clk;
	logic rst;
	logic store_strb;
	logic p2_bunch_strb;
	logic p3_bunch_strb;
	logic feedbck_en;
	logic delay_loop_en;
	logic const_dac_en;
	sample_t p2_sigma;
	sample_t p2_delta;
	sample_t p3_sigma;
	sample_t p3_delta;
	sample_t const_dac_code;
	logic p2_lut_we;
	logic p3_lut_we;
	addr_t p2_lut_addr;
	addr_t p3_lut_addr;
	gain_t p2_lut_data;
	gain_t p3_lut_data;
	sample_t amp_drive;
	logic dac_en;

	fb_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.store_strb     (store_strb),
		.p2_bunch_strb  (p2_bunch_strb),
		.p3_bunch_strb  (p3_bunch_strb),
		.feedbck_en     (feedbck_en),
		.delay_loop_en  (delay_loop_en),
		.const_dac_en   (const_dac_en),
		.p2_sigma       (p2_sigma),
		.p2_delta       (p2_delta),
		.p3_sigma       (p3_sigma),
		.p3_delta       (p3_delta),
		.const_dac_code (const_dac_code),
		.p2_lut_we      (p2_lut_we),
		.p3_lut_we      (p3_lut_we),
		.p2_lut_addr    (p2_lut_addr),
		.p3_lut_addr    (p3_lut_addr),
		.p2_lut_data    (p2_lut_data),
		.p3_lut_data    (p3_lut_data),
		.amp_drive      (amp_drive),
		.dac_en         (dac_en)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ##################################################################
	// reference model state

	// table copies
	gain_t l2_model [0:lut_depth-1];
	gain_t l3_model [0:lut_depth-1];
	longint m_p2_store;
	longint m_delay;
	logic [31:0] lfsr_state;
	int checks;
	int value_errors;
	int other_errors;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// small signed gain sign extended to a table word
	function automatic gain_t rand_gain(input int nbits);
		int v;
		v = int'(take_bits(nbits) << (32 - nbits)) >>> (32 - nbits);
		return gain_t'(v);
	endfunction

	// gain x delta with the 4096 scale
	function automatic longint kick(input gain_t g, input sample_t d);
		return longint'(g) * longint'(d);
	endfunction

	// 48 bit accumulator wrap
	function automatic longint wrap_acc(input longint v);
		return longint'(acc_t'(v));
	endfunction

	// 13 bit dac range
	function automatic sample_t sat_dac(input longint v);
		if (v > 4095) begin
			return sample_t'(4095);
		end
		if (v < -4096) begin
			return sample_t'(-4096);
		end
		return sample_t'(v);
	endfunction

	// ##################################################################
	// drive and check helpers

	// inputs change and outputs are read here
	task automatic wait_cycle();
		@(posedge clk);
		#(drive_dly);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			value_errors++;
			$display("FAIL %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// wait for the dac pulse, check the code, wait for its end
	task automatic expect_kick(input sample_t expected);
		int n;
		n = 0;
		while (dac_en !== 1'b1 && n < dac_wait) begin
			wait_cycle();
			n++;
		end
		if (dac_en !== 1'b1) begin
			other_errors++;
			$display("ERROR: no dac_en pulse within %0d cycles", dac_wait);
		end else begin
			check_value("amp_drive", 32'(amp_drive), 32'(expected));
			while (dac_en === 1'b1) begin
				wait_cycle();
			end
		end
	endtask

	// one bunch of p2 then p3 with controls held steady
	task automatic run_bunch(input sample_t s2, input sample_t d2,
			input sample_t s3, input sample_t d3);
		longint sum;
		sample_t expected;
		// stores only load while store is high
		if (store_strb) begin
			m_p2_store = kick(l2_model[addr_t'(s2)], d2);
		end
		sum = wrap_acc(kick(l3_model[addr_t'(s3)], d3) + m_delay + m_p2_store);
		if (store_strb) begin
			if (delay_loop_en) begin
				m_delay = sum;
			end else begin
				m_delay = 0;
			end
		end
		if (!store_strb || !feedbck_en) begin
			expected = '0;
		end else if (const_dac_en) begin
			expected = const_dac_code;
		end else begin
			expected = sat_dac(sum >>> scale_shift);
		end
		p2_sigma = s2;
		p2_delta = d2;
		p2_bunch_strb = 1'b1;
		wait_cycle();
		p2_bunch_strb = 1'b0;
		repeat (strobe_gap - 1) begin
			wait_cycle();
		end
		p3_sigma = s3;
		p3_delta = d3;
		p3_bunch_strb = 1'b1;
		wait_cycle();
		p3_bunch_strb = 1'b0;
		expect_kick(expected);
		repeat (4) begin
			wait_cycle();
		end
	endtask

	task automatic run_random_bunch();
		sample_t s2;
		sample_t d2;
		sample_t s3;
		sample_t d3;
		s2 = sample_t'(take_bits(sample_w));
		d2 = sample_t'(take_bits(sample_w));
		s3 = sample_t'(take_bits(sample_w));
		d3 = sample_t'(take_bits(sample_w));
		run_bunch(s2, d2, s3, d3);
	endtask

	// store falls and the zero strobe gives one dac pulse with code 0
	task automatic end_store();
		store_strb = 1'b0;
		m_p2_store = 0;
		m_delay = 0;
		wait_cycle();
		expect_kick('0);
		for (int n = 0; n < dac_wait; n++) begin
			wait_cycle();
			if (dac_en === 1'b1) begin
				other_errors++;
				$display("ERROR: extra dac_en pulse after the store falling edge");
			end
		end
	endtask

	task automatic start_store();
		store_strb = 1'b1;
		repeat (4) begin
			wait_cycle();
		end
	endtask

	task automatic write_gains(input addr_t a2, input gain_t g2, input addr_t a3,
			input gain_t g3);
		p2_lut_we = 1'b1;
		p3_lut_we = 1'b1;
		p2_lut_addr = a2;
		p3_lut_addr = a3;
		p2_lut_data = g2;
		p3_lut_data = g3;
		l2_model[a2] = g2;
		l3_model[a3] = g3;
		wait_cycle();
		p2_lut_we = 1'b0;
		p3_lut_we = 1'b0;
		// keep writes clear of the next strobe
		repeat (6) begin
			wait_cycle();
		end
	endtask

	// every address gets a random gain
	task automatic fill_tables();
		gain_t g2;
		gain_t g3;
		for (int a = 0; a < lut_depth; a++) begin
			g2 = rand_gain(12);
			g3 = rand_gain(12);
			p2_lut_we = 1'b1;
			p3_lut_we = 1'b1;
			p2_lut_addr = addr_t'(a);
			p3_lut_addr = addr_t'(a);
			p2_lut_data = g2;
			p3_lut_data = g3;
			l2_model[addr_t'(a)] = g2;
			l3_model[addr_t'(a)] = g3;
			wait_cycle();
		end
		p2_lut_we = 1'b0;
		p3_lut_we = 1'b0;
		repeat (6) begin
			wait_cycle();
		end
	endtask

	// ##################################################################
	// test sequence

	initial begin
		addr_t sa2;
		addr_t sa3;
		rst = 1'b1;
		store_strb = 1'b0;
		p2_bunch_strb = 1'b0;
		p3_bunch_strb = 1'b0;
		feedbck_en = 1'b0;
		delay_loop_en = 1'b0;
		const_dac_en = 1'b0;
		p2_sigma = '0;
		p2_delta = '0;
		p3_sigma = '0;
		p3_delta = '0;
		const_dac_code = '0;
		p2_lut_we = 1'b0;
		p3_lut_we = 1'b0;
		p2_lut_addr = '0;
		p3_lut_addr = '0;
		p2_lut_data = '0;
		p3_lut_data = '0;
		lfsr_state = seed;
		m_p2_store = 0;
		m_delay = 0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (5) @(posedge clk);
		#(drive_dly);
		rst = 1'b0;

		// idle outputs before any strobe
		repeat (8) begin
			wait_cycle();
			check_value("dac_en", 32'(dac_en), 32'd0);
			check_value("amp_drive", 32'(amp_drive), 32'd0);
		end
		fill_tables();
		check_value("dac_en", 32'(dac_en), 32'd0);

		// p3 kick with p2 store and no loop
		feedbck_en = 1'b1;
		start_store();
		repeat (6) begin
			run_random_bunch();
		end
		end_store();

		// loop accumulation then a fresh store period
		delay_loop_en = 1'b1;
		start_store();
		repeat (6) begin
			run_random_bunch();
		end
		end_store();
		start_store();
		repeat (3) begin
			run_random_bunch();
		end
		end_store();

		// full-scale gains drive both saturation limits
		delay_loop_en = 1'b0;
		start_store();
		sa2 = addr_t'(take_bits(lut_addr_w));
		sa3 = addr_t'(take_bits(lut_addr_w));
		write_gains(sa2, gain_t'(1048575), sa3, gain_t'(1048575));
		run_bunch(sample_t'(sa2), sample_t'(4095), sample_t'(sa3), sample_t'(4095));
		check_value("amp_drive", 32'(amp_drive), 32'(sample_t'(4095)));
		run_bunch(sample_t'(sa2), sample_t'(-4096), sample_t'(sa3), sample_t'(-4096));
		check_value("amp_drive", 32'(amp_drive), 32'(sample_t'(-4096)));

		// constant code while the loop keeps running underneath
		delay_loop_en = 1'b1;
		const_dac_en = 1'b1;
		const_dac_code = sample_t'(take_bits(sample_w));
		repeat (2) begin
			run_random_bunch();
		end
		const_dac_en = 1'b0;
		run_random_bunch();

		// same again with feedback off
		feedbck_en = 1'b0;
		repeat (2) begin
			run_random_bunch();
		end
		feedbck_en = 1'b1;
		run_random_bunch();

		// store low so nothing is captured
		end_store();
		run_random_bunch();
		start_store();
		run_random_bunch();

		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// ##################################################################
	// watchdog

	initial begin
		#(timeout_ns);
		$display("ERROR: watchdog expired after %0d ns, run did not finish", timeout_ns);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/fb_dsp_pkg.sv
hdl/fb_timing_pkg.sv
hdl/strobe_if.sv
hdl/strobe_timing.sv
hdl/pickup_scaler.sv
hdl/kick_accumulator.sv
hdl/dac_output_stage.sv
hdl/fb_top.sv
verification/fb_top_chk.sv
verification/tb_fb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fb_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
